// File: Bender.yml
package:
  name: fetch_front_end

dependencies: {}

sources:
  # Design, package first
  - files:
      - verilog/fetchPkg.sv
      - verilog/instrCacheFully.sv
      - verilog/fetchMissCtrl.sv
      - verilog/pcSequencer.sv
      - verilog/instrMemory.sv
      - verilog/fetchTop.sv

  # Testbench
  - target: simulation
    files:
      - sim/tbClockGen.sv
      - sim/tb_fetchTop.sv

// File: sim/tbClockGen.sv
`timescale 1ns/1ps
// Testbench clock source and active-low synchronous reset generator
module tbClockGen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic RESET
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        RESET = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        RESET <= 1'b1; // Released on a rising edge
    end

endmodule

// File: sim/tb_fetchTop.sv
`timescale 1ns/1ps
// Fetch front end testbench: stimulus, FIFO cache reference model, checker and watchdog
module tb_fetchTop;
    import fetchPkg::*;

    localparam int NUM_ENTRIES  = 8;
    localparam int MEM_LATENCY  = 3;
    localparam int RESET_CYCLES = 4;
    localparam int LOAD_WORDS   = 64;
    localparam int RAND_RUNS    = 200;
    localparam int MAX_RUN      = 4;
    localparam int MAX_FETCHES  = 29 + RAND_RUNS * MAX_RUN;
    localparam int WATCHDOG_CYCLES =
        MAX_FETCHES * (MEM_LATENCY + 4) * 2 + LOAD_WORDS + RESET_CYCLES + 50;

    logic clk;
    logic RESET;
    logic loadEn;
    addrT loadAddr;
    wordT loadData;
    logic fetchEnable;
    logic redirectValid;
    addrT redirectPc;
    logic instrValid;
    wordT instr;
    addrT instrPc;
    cntT  cntHit;
    cntT  cntMiss;

    // Reference state
    wordT        memCopy [LOAD_WORDS];
    logic        modelValid [NUM_ENTRIES];
    tagT         modelTag [NUM_ENTRIES];
    int          modelPtr;
    int          modelHits;
    int          modelMisses;
    logic [31:0] rngState;
    addrT        expPc;        // Next pc the checker expects
    logic        expHit;
    wordT        expWord;
    int          delivered;
    int          target;
    int          errorCount;

    tbClockGen #(.PERIOD_NS(4.0), .RESET_CYCLES(RESET_CYCLES)) u_clkGen (
        .clk(clk), .RESET(RESET)
    );

    fetchTop u_dut (
        .clk(clk), .RESET(RESET), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .fetchEnable(fetchEnable), .redirectValid(redirectValid),
        .redirectPc(redirectPc), .instrValid(instrValid), .instr(instr),
        .instrPc(instrPc), .cntHit(cntHit), .cntMiss(cntMiss)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 8-entry fully associative FIFO cache over the memory copy
    function automatic void predictFetch(input addrT fetchPc, output logic hit,
                                         output wordT word);
        tagT tag;
        tag = fetchPc[31:2];
        hit = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (modelValid[i] && modelTag[i] == tag) begin
                hit = 1'b1;
            end
        end
        word = memCopy[fetchPc[7:2]];
        if (hit) begin
            modelHits++;
        end else begin
            modelValid[modelPtr] = 1'b1;
            modelTag[modelPtr]   = tag;
            modelPtr    = (modelPtr + 1) % NUM_ENTRIES;
            modelMisses++;
        end
    endfunction

    // Compare each delivered instruction
    always @(negedge clk) begin
        if (RESET === 1'b1 && instrValid === 1'b1) begin
            if (delivered >= target) begin
                $display("** Error at %0t: instrValid with no fetch outstanding", $time);
                errorCount++;
            end
            predictFetch(expPc, expHit, expWord);
            if (instrPc !== expPc) begin
                $display("** Error at %0t: instrPc %h, expected %h", $time, instrPc, expPc);
                errorCount++;
            end
            if (instr !== expWord) begin
                $display("** Error at %0t: instr %h at pc %h, expected %h",
                         $time, instr, expPc, expWord);
                errorCount++;
            end
            if (cntHit !== cntT'(modelHits) || cntMiss !== cntT'(modelMisses)) begin
                $display("** Error at %0t: pc %h expected %s, counters hit %0d miss %0d",
                         $time, expPc, expHit ? "hit" : "miss", cntHit, cntMiss);
                errorCount++;
            end
            expPc = expPc + 4;
            delivered++;
        end
    end

    task automatic loadMemory();
        for (int i = 0; i < LOAD_WORDS; i++) begin
            rngState   = xorshift32(rngState);
            memCopy[i] = rngState;
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= addrT'(i * 4);
            loadData <= rngState;
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    // Redirect while idle, then fetch exactly count instructions
    task automatic runFetches(input addrT startPc, input int count);
        target = delivered + count;
        expPc  = startPc;
        @(posedge clk);
        redirectValid <= 1'b1;
        redirectPc    <= startPc;
        @(posedge clk);
        redirectValid <= 1'b0;
        fetchEnable   <= 1'b1;
        @(posedge clk);
        while (delivered < target - 1) @(posedge clk);
        fetchEnable <= 1'b0; // Last lookup already committed
        while (delivered < target) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic checkCounters(input int hits, input int misses, input string step);
        @(negedge clk);
        if (cntHit !== cntT'(hits) || cntMiss !== cntT'(misses)) begin
            $display("** Error at %0t: %s counters hit %0d miss %0d, expected %0d %0d",
                     $time, step, cntHit, cntMiss, hits, misses);
            errorCount++;
        end
    endtask

    initial begin
        logic [31:0] startIdx;
        logic [31:0] runLen;
        loadEn        = 1'b0;
        loadAddr      = '0;
        loadData      = '0;
        fetchEnable   = 1'b0;
        redirectValid = 1'b0;
        redirectPc    = '0;
        rngState      = 32'd88961;
        modelPtr      = 0;
        modelHits     = 0;
        modelMisses   = 0;
        delivered     = 0;
        target        = 0;
        errorCount    = 0;
        expPc         = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            modelValid[i] = 1'b0;
            modelTag[i]   = '0;
        end
        wait (RESET === 1'b1);
        loadMemory();
        repeat (4) @(negedge clk);  // Idle, nothing may be delivered
        checkCounters(0, 0, "idle");
        runFetches(32'h0, 12);      // Cold run
        checkCounters(0, 12, "cold run");
        runFetches(32'h10, 8);      // Words 4 to 11 still cached
        checkCounters(8, 12, "refetch");
        runFetches(32'h0, 1);       // Evicted, refill replaces word 4
        checkCounters(8, 13, "evicted word");
        runFetches(32'h14, 7);
        checkCounters(15, 13, "surviving words");
        runFetches(32'h10, 1);
        checkCounters(15, 14, "replaced word");
        for (int r = 0; r < RAND_RUNS; r++) begin
            rngState = xorshift32(rngState);
            startIdx = rngState % 32;
            rngState = xorshift32(rngState);
            runLen   = rngState % MAX_RUN + 1;
            runFetches(addrT'(startIdx * 4), int'(runLen));
        end
        checkCounters(modelHits, modelMisses, "random runs");
        $display("Run complete: %0d errors, %0d instructions delivered",
                 errorCount, delivered);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the fetch count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: fetches did not finish within %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, errorCount);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: sources.f
verilog/fetchPkg.sv
verilog/instrCacheFully.sv
verilog/fetchMissCtrl.sv
verilog/pcSequencer.sv
verilog/instrMemory.sv
verilog/fetchTop.sv
sim/tbClockGen.sv
sim/tb_fetchTop.sv

// File: verilog/fetchMissCtrl.sv
`timescale 1ns/1ps
// Fetch FSM: issues lookups, handles misses with a memory read and a cache fill
module fetchMissCtrl (
    input  logic                clk,
    input  logic                RESET,
    input  logic                fetchEnable,
    input  fetchPkg::addrT      pc,
    input  logic                respValid,
    input  fetchPkg::fetchRespT resp,
    output logic                lookup,
    output logic                memReq,
    output fetchPkg::addrT      memAddr,
    input  logic                memValid,
    input  fetchPkg::wordT      memData,
    output logic                fillValid,
    output fetchPkg::fillT      fill
);
    import fetchPkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,    // Lookup issued, waiting for the cache
        ST_MEM_WAIT,  // Memory read outstanding
        ST_FILL       // Fill strobe out, cache answers next
    } stateT;

    stateT state;
    addrT  reqPc;     // PC the cache saw in the lookup cycle

    assign memAddr = reqPc;

    always_ff @(posedge clk) begin
        if (lookup) begin
            reqPc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!RESET) begin
            state     <= ST_IDLE;
            lookup    <= 1'b0;
            memReq    <= 1'b0;
            fillValid <= 1'b0;
        end else begin
            // Strobes default low
            lookup    <= 1'b0;
            memReq    <= 1'b0;
            fillValid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fetchEnable) begin
                        lookup <= 1'b1;
                        state  <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (respValid) begin
                        if (!resp.hit) begin
                            memReq <= 1'b1;
                            state  <= ST_MEM_WAIT;
                        end else if (fetchEnable) begin
                            lookup <= 1'b1; // PC has advanced by now
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_MEM_WAIT: begin
                    if (memValid) begin
                        fillValid <= 1'b1;
                        state     <= ST_FILL;
                    end
                end
                ST_FILL: state <= ST_LOOKUP; // Fill response delivers the word
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Fill payload captured with the memory word
    always_ff @(posedge clk) begin
        if (memValid) begin
            fill.pc   <= reqPc;
            fill.data <= memData;
        end
    end

endmodule

// File: verilog/fetchPkg.sv
// Shared widths, address/word/tag/counter typedefs, cache line, fill and response structs
package fetchPkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int TAG_W  = ADDR_W - 2; // One word per line, drop byte offset
    localparam int CNT_W  = 20;

    typedef logic [ADDR_W-1:0] addrT;  // Byte address or PC
    typedef logic [WORD_W-1:0] wordT;  // Instruction word
    typedef logic [TAG_W-1:0]  tagT;   // Full word address
    typedef logic [CNT_W-1:0]  cntT;   // Hit or miss count

    // Stored cache entry
    typedef struct packed {
        logic valid;
        tagT  tag;
        wordT data;
    } cacheLineT;

    // Word handed to the cache after a memory read
    typedef struct packed {
        addrT pc;
        wordT data;
    } fillT;

    // Registered cache result
    typedef struct packed {
        logic hit;
        addrT pc;
        wordT data;
    } fetchRespT;

    // Tag of a fetch address
    function automatic tagT pcToTag(addrT pc);
        return pc[ADDR_W-1:2];
    endfunction

endpackage

// File: verilog/fetchTop.sv
`timescale 1ns/1ps
// Fetch front end top: PC sequencer, miss FSM, instruction cache and memory model
module fetchTop #(
    parameter int             NUM_ENTRIES   = 8,
    parameter int             MEM_LATENCY   = 3,
    parameter int             MEM_ADDR_BITS = 10,
    parameter fetchPkg::addrT RESET_PC      = '0
) (
    input  logic           clk,
    input  logic           RESET,
    input  logic           loadEn,
    input  fetchPkg::addrT loadAddr,
    input  fetchPkg::wordT loadData,
    input  logic           fetchEnable,
    input  logic           redirectValid,
    input  fetchPkg::addrT redirectPc,
    output logic           instrValid,
    output fetchPkg::wordT instr,
    output fetchPkg::addrT instrPc,
    output fetchPkg::cntT  cntHit,
    output fetchPkg::cntT  cntMiss
);
    import fetchPkg::*;

    addrT      pc;
    logic      lookup;
    logic      respValid;
    fetchRespT resp;
    logic      memReq;
    addrT      memAddr;
    logic      memValid;
    wordT      memData;
    logic      fillValid;
    fillT      fill;

    // Delivered instruction
    assign instrValid = respValid & resp.hit;
    assign instr      = resp.data;
    assign instrPc    = resp.pc;

    pcSequencer #(.RESET_PC(RESET_PC)) u_pcSeq (
        .clk(clk), .RESET(RESET), .instrValid(instrValid),
        .redirectValid(redirectValid), .redirectPc(redirectPc), .pc(pc)
    );

    fetchMissCtrl u_missCtrl (
        .clk(clk), .RESET(RESET), .fetchEnable(fetchEnable), .pc(pc),
        .respValid(respValid), .resp(resp), .lookup(lookup),
        .memReq(memReq), .memAddr(memAddr), .memValid(memValid), .memData(memData),
        .fillValid(fillValid), .fill(fill)
    );

    instrCacheFully #(.NUM_ENTRIES(NUM_ENTRIES)) u_cache (
        .clk(clk), .RESET(RESET), .lookup(lookup), .pc(pc),
        .fillValid(fillValid), .fill(fill), .respValid(respValid), .resp(resp),
        .cntHit(cntHit), .cntMiss(cntMiss)
    );

    instrMemory #(
        .MEM_ADDR_BITS(MEM_ADDR_BITS),
        .MEM_LATENCY(MEM_LATENCY)
    ) u_mem (
        .clk(clk), .RESET(RESET), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .memReq(memReq), .memAddr(memAddr),
        .memValid(memValid), .memData(memData)
    );

endmodule

// File: verilog/instrCacheFully.sv
`timescale 1ns/1ps
// Fully associative one-word-per-line instruction cache, FIFO replacement, hit/miss counters
module instrCacheFully #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                clk,
    input  logic                RESET,
    input  logic                lookup,
    input  fetchPkg::addrT      pc,
    input  logic                fillValid,
    input  fetchPkg::fillT      fill,
    output logic                respValid,
    output fetchPkg::fetchRespT resp,
    output fetchPkg::cntT       cntHit,
    output fetchPkg::cntT       cntMiss
);
    import fetchPkg::*;

    localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(NUM_ENTRIES - 1);

    cacheLineT              lines [NUM_ENTRIES];
    logic [PTR_W-1:0]       fifoPtr;    // Oldest entry, next to be replaced
    logic [NUM_ENTRIES-1:0] hitVec;
    logic                   hitAny;
    wordT                   hitData;
    tagT                    lookupTag;

    assign lookupTag = pcToTag(pc);

    // Parallel compare against every entry
    always_comb begin
        hitData = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            hitVec[i] = lines[i].valid && (lines[i].tag == lookupTag);
            if (hitVec[i]) begin
                hitData = hitData | lines[i].data; // At most one match
            end
        end
    end

    assign hitAny = |hitVec;

    // Entry storage and FIFO pointer
    always_ff @(posedge clk) begin
        if (!RESET) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                lines[i].valid <= 1'b0;
            end
            fifoPtr <= '0;
        end else if (fillValid) begin
            lines[fifoPtr] <= '{valid: 1'b1, tag: pcToTag(fill.pc), data: fill.data};
            if (fifoPtr == LAST_PTR) begin
                fifoPtr <= '0; // Wrap to the first entry
            end else begin
                fifoPtr <= fifoPtr + 1'b1;
            end
        end
    end

    // Response strobe and counters
    always_ff @(posedge clk) begin
        if (!RESET) begin
            respValid <= 1'b0;
            cntHit    <= '0;
            cntMiss   <= '0;
        end else begin
            respValid <= lookup | fillValid;
            if (lookup && !fillValid) begin
                if (hitAny) begin
                    cntHit <= cntHit + 1'b1;
                end else begin
                    cntMiss <= cntMiss + 1'b1;
                end
            end
        end
    end

    // Registered result, fill wins over lookup
    always_ff @(posedge clk) begin
        if (fillValid) begin
            resp.hit  <= 1'b1;
            resp.pc   <= fill.pc;
            resp.data <= fill.data;   // Filled word returned as a hit
        end else if (lookup) begin
            resp.hit  <= hitAny;
            resp.pc   <= pc;
            resp.data <= hitData;     // Zero on a miss
        end
    end

endmodule

// File: verilog/instrMemory.sv
`timescale 1ns/1ps
// Word-addressed instruction memory model with load port and fixed read latency
module instrMemory #(
    parameter int MEM_ADDR_BITS = 10,
    parameter int MEM_LATENCY   = 3
) (
    input  logic           clk,
    input  logic           RESET,
    input  logic           loadEn,
    input  fetchPkg::addrT loadAddr,
    input  fetchPkg::wordT loadData,
    input  logic           memReq,
    input  fetchPkg::addrT memAddr,
    output logic           memValid,
    output fetchPkg::wordT memData
);
    import fetchPkg::*;

    localparam int DEPTH = 1 << MEM_ADDR_BITS;

    wordT                   mem [DEPTH];
    logic [MEM_ADDR_BITS-1:0] wrIdx;
    logic [MEM_ADDR_BITS-1:0] rdIdx;
    logic [MEM_LATENCY-1:0] validPipe;
    wordT                   dataPipe [MEM_LATENCY];

    // Byte address to word index
    assign wrIdx = loadAddr[MEM_ADDR_BITS+1:2];
    assign rdIdx = memAddr[MEM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[wrIdx] <= loadData;
        end
    end

    // Valid pipeline, cleared on reset
    always_ff @(posedge clk) begin
        if (!RESET) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= memReq;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    // Data travels alongside
    always_ff @(posedge clk) begin
        dataPipe[0] <= mem[rdIdx];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    assign memValid = validPipe[MEM_LATENCY-1];
    assign memData  = dataPipe[MEM_LATENCY-1];

endmodule

// File: verilog/pcSequencer.sv
`timescale 1ns/1ps
// Fetch program counter with sequential increment and redirect
module pcSequencer #(
    parameter fetchPkg::addrT RESET_PC = '0
) (
    input  logic           clk,
    input  logic           RESET,
    input  logic           instrValid,
    input  logic           redirectValid,
    input  fetchPkg::addrT redirectPc,
    output fetchPkg::addrT pc
);
    import fetchPkg::*;

    localparam addrT INSTR_BYTES = addrT'(4);

    addrT pcNext;

    // Redirect beats the increment
    always_comb begin
        if (redirectValid) begin
            pcNext = redirectPc;
        end else if (instrValid) begin
            pcNext = pc + INSTR_BYTES;
        end else begin
            pcNext = pc;  // Hold while a fetch is in flight
        end
    end

    always_ff @(posedge clk) begin
        if (!RESET) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

endmodule
